// File: Bender.yml
package:
  name: systolic_mm

sources:
  - source/systolic_pkg.sv
  - source/feed_if.sv
  - source/operand_feeder.sv
  - source/pe_cell.sv
  - source/pe_array.sv
  - source/mm_controller.sv
  - source/result_unloader.sv
  - source/systolic_top.sv
  - target: test
    files:
      - tb/tb_systolic.sv

// File: all.f
source/systolic_pkg.sv
source/feed_if.sv
source/operand_feeder.sv
source/pe_cell.sv
source/pe_array.sv
source/mm_controller.sv
source/result_unloader.sv
source/systolic_top.sv
tb/tb_systolic.sv

// File: source/feed_if.sv
/* one instance per operand side; load and advance never occur in the same cycle
   lanes hold the skewed wavefront presented to the array edge */
interface feed_if;

    logic                                load;
    logic [systolic_pkg::BEAT_W-1:0]     beat;      // row of the holding store
    systolic_pkg::lanes_t                operands;
    logic                                advance;   // one wavefront step
    systolic_pkg::lanes_t                lanes;

    modport source (
        output load,
        output beat,
        output operands,
        output advance
    );

    modport feeder (
        input  load,
        input  beat,
        input  operands,
        input  advance,
        output lanes
    );

    modport sink (
        input lanes,
        input advance
    );

endinterface

// File: source/mm_controller.sv
/* accepts IN_BEATS words, then clears, steps the array FEED_STEPS times and snapshots
   no new input is taken until the unloader reports the last output word */
module mm_controller (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid_i,
    input  logic [systolic_pkg::WORD_W-1:0] in_data_i,
    output logic                            in_ready_o,
    feed_if.source                          feed_a,
    feed_if.source                          feed_b,
    output logic                            clear_o,
    output logic                            snap_o,
    input  logic                            drained_i
);

    logic [systolic_pkg::STATE_W-1:0] state_q;
    logic [systolic_pkg::STATE_W-1:0] state_d;
    logic [systolic_pkg::BEAT_W-1:0]  beat_q;
    logic [systolic_pkg::STEP_W-1:0]  step_q;
    logic                             ready_q;
    logic                             accept;
    logic                             last_beat;
    logic                             last_step;
    systolic_pkg::in_word_u           in_word;

    assign in_word.raw = in_data_i;
    assign in_ready_o  = ready_q;
    assign accept      = in_valid_i && ready_q;
    assign last_beat   = beat_q == systolic_pkg::BEAT_W'(systolic_pkg::IN_BEATS - 1);
    assign last_step   = step_q == systolic_pkg::STEP_W'(systolic_pkg::FEED_STEPS - 1);

    // same beat goes to both feeders, each takes its own half
    assign feed_a.load     = accept;
    assign feed_a.beat     = beat_q;
    assign feed_a.operands = in_word.operands.a_row;
    assign feed_a.advance  = state_q == systolic_pkg::ST_FEED;
    assign feed_b.load     = accept;
    assign feed_b.beat     = beat_q;
    assign feed_b.operands = in_word.operands.b_col;
    assign feed_b.advance  = state_q == systolic_pkg::ST_FEED;

    assign clear_o = state_q == systolic_pkg::ST_CLEAR;
    assign snap_o  = state_q == systolic_pkg::ST_SNAP;

    always_comb begin
        state_d = state_q;
        case (state_q)
            systolic_pkg::ST_ACCEPT: begin
                if (accept && last_beat) begin
                    state_d = systolic_pkg::ST_CLEAR;
                end
            end
            systolic_pkg::ST_CLEAR: begin
                state_d = systolic_pkg::ST_FEED;
            end
            systolic_pkg::ST_FEED: begin
                if (last_step) begin
                    state_d = systolic_pkg::ST_SNAP;
                end
            end
            systolic_pkg::ST_SNAP: begin
                state_d = systolic_pkg::ST_WAIT_DRAIN;
            end
            systolic_pkg::ST_WAIT_DRAIN: begin
                if (drained_i) begin
                    state_d = systolic_pkg::ST_ACCEPT;
                end
            end
            default: begin
                state_d = systolic_pkg::ST_ACCEPT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= systolic_pkg::ST_ACCEPT;
            ready_q <= 1'b0;  // rises one cycle after reset
            beat_q  <= '0;
            step_q  <= '0;
        end else begin
            state_q <= state_d;
            ready_q <= state_d == systolic_pkg::ST_ACCEPT;
            if (accept) begin
                beat_q <= last_beat ? '0 : beat_q + 1'b1;
            end
            if (state_q == systolic_pkg::ST_FEED) begin
                step_q <= last_step ? '0 : step_q + 1'b1;
            end
        end
    end

endmodule

// File: source/operand_feeder.sv
/* beats must arrive in order 0..N-1; loading beat 0 restarts the wavefront
   lane k presents element j of the vector loaded at beat k during step j+k, zero otherwise */
module operand_feeder (
    input logic    clk,
    input logic    reset,
    feed_if.feeder feed
);

    systolic_pkg::lanes_t                store [systolic_pkg::N];  // one vector per lane
    systolic_pkg::lanes_t                lanes_q;
    systolic_pkg::lanes_t                next_lanes;
    logic [systolic_pkg::STEP_W-1:0]     step_q;   // step currently on the lanes

    always_ff @(posedge clk) begin
        if (feed.load) begin
            store[feed.beat] <= feed.operands;
        end
    end

    // wavefront for the step after the current one
    always_comb begin
        int elem;
        next_lanes = '0;
        for (int k = 0; k < systolic_pkg::N; k++) begin
            elem = int'(step_q) + 1 - k;
            if (elem >= 0 && elem < systolic_pkg::N) begin
                next_lanes[k] = store[k][elem];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step_q  <= '0;
            lanes_q <= '0;
        end else if (feed.load && feed.beat == '0) begin
            step_q  <= '0;
            // step 0 only reaches lane 0, and its vector is the one arriving now
            lanes_q <= {{((systolic_pkg::N - 1) * systolic_pkg::DATA_W){1'b0}},
                        feed.operands[0]};
        end else if (feed.advance) begin
            step_q  <= step_q + 1'b1;
            lanes_q <= next_lanes;
        end
    end

    assign feed.lanes = lanes_q;

endmodule

// File: source/pe_array.sv
/* A lanes enter at the left edge and B lanes at the top; feed_a advance steps every cell
   sums_o holds C in row-major order, C[i][j] at index i*N+j */
module pe_array (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               clear_i,
    feed_if.sink                                               feed_a,
    feed_if.sink                                               feed_b,
    output logic [systolic_pkg::N*systolic_pkg::N-1:0][systolic_pkg::ACC_W-1:0] sums_o
);

    // extra column and row carry the edge inputs
    logic signed [systolic_pkg::DATA_W-1:0] a_bus [systolic_pkg::N][systolic_pkg::N+1];
    logic signed [systolic_pkg::DATA_W-1:0] b_bus [systolic_pkg::N+1][systolic_pkg::N];

    for (genvar e = 0; e < systolic_pkg::N; e++) begin : g_edge
        assign a_bus[e][0] = feed_a.lanes[e];  // row e of A
        assign b_bus[0][e] = feed_b.lanes[e];  // column e of B
    end

    for (genvar i = 0; i < systolic_pkg::N; i++) begin : g_row
        for (genvar j = 0; j < systolic_pkg::N; j++) begin : g_col
            pe_cell u_cell (
                .clk     (clk),
                .reset   (reset),
                .clear_i (clear_i),
                .step_i  (feed_a.advance),
                .a_i     (a_bus[i][j]),
                .b_i     (b_bus[i][j]),
                .a_o     (a_bus[i][j+1]),
                .b_o     (b_bus[i+1][j]),
                .acc_o   (sums_o[i*systolic_pkg::N+j])
            );
        end
    end

endmodule

// File: source/pe_cell.sv
/* accumulates and forwards only on step_i; clear_i wins over step_i */
module pe_cell (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear_i,
    input  logic                                  step_i,
    input  logic signed [systolic_pkg::DATA_W-1:0] a_i,
    input  logic signed [systolic_pkg::DATA_W-1:0] b_i,
    output logic signed [systolic_pkg::DATA_W-1:0] a_o,
    output logic signed [systolic_pkg::DATA_W-1:0] b_o,
    output logic signed [systolic_pkg::ACC_W-1:0]  acc_o
);

    logic signed [2*systolic_pkg::DATA_W-1:0] prod;

    assign prod = a_i * b_i;  // full 16-bit signed product

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else if (clear_i) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else if (step_i) begin
            a_o   <= a_i;          // to the right neighbour
            b_o   <= b_i;          // to the cell below
            acc_o <= acc_o + prod; // sign extended to ACC_W
        end
    end

endmodule

// File: source/result_unloader.sv
/* word k carries sums 2k (low half) and 2k+1 (high half); data holds while out_ready_i is low
   snap_i must not arrive while a previous result is still draining */
module result_unloader (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               snap_i,
    input  logic [systolic_pkg::N*systolic_pkg::N-1:0][systolic_pkg::ACC_W-1:0] sums_i,
    output logic                                               out_valid_o,
    output logic [systolic_pkg::WORD_W-1:0]                    out_data_o,
    input  logic                                               out_ready_i,
    output logic                                               drained_o
);

    // two row-major sums per word, so the sum vector maps straight onto the words
    logic [systolic_pkg::OUT_BEATS-1:0][systolic_pkg::WORD_W-1:0] words_q;
    logic [systolic_pkg::OUT_IDX_W-1:0]                           idx_q;
    logic                                                         valid_q;
    logic                                                         xfer;
    logic                                                         last_word;

    assign xfer      = valid_q && out_ready_i;
    assign last_word = idx_q == systolic_pkg::OUT_IDX_W'(systolic_pkg::OUT_BEATS - 1);

    always_ff @(posedge clk) begin
        if (snap_i) begin
            words_q <= sums_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            idx_q   <= '0;
        end else if (snap_i) begin
            valid_q <= 1'b1;
            idx_q   <= '0;
        end else if (xfer) begin
            if (last_word) begin
                valid_q <= 1'b0;
                idx_q   <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = words_q[idx_q];
    assign drained_o   = xfer && last_word;  // eighth word leaving

endmodule

// File: source/systolic_pkg.sv
/* fixed 4x4 array of signed int8 operands with 32-bit sums; no other size is supported
   input beat i packs row i of A in the low half and column i of B in the high half */
package systolic_pkg;

    localparam int N          = 4;
    localparam int DATA_W     = 8;   // signed operands
    localparam int ACC_W      = 32;  // sixteen int8 products always fit
    localparam int WORD_W     = 64;  // stream word on both sides

    localparam int IN_BEATS   = N;
    localparam int OUT_BEATS  = N * N * ACC_W / WORD_W;
    // last operand pair lands in cell (N-1, N-1) on this step count
    localparam int FEED_STEPS = 3 * N - 2;

    localparam int BEAT_W     = $clog2(IN_BEATS);
    localparam int STEP_W     = $clog2(FEED_STEPS + 1);
    localparam int OUT_IDX_W  = $clog2(OUT_BEATS);

    // controller state encoding
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_ACCEPT     = 3'd0;
    localparam logic [STATE_W-1:0] ST_CLEAR      = 3'd1;
    localparam logic [STATE_W-1:0] ST_FEED       = 3'd2;
    localparam logic [STATE_W-1:0] ST_SNAP       = 3'd3;
    localparam logic [STATE_W-1:0] ST_WAIT_DRAIN = 3'd4;

    // one operand per lane, lane 0 in the low byte
    typedef logic signed [N-1:0][DATA_W-1:0] lanes_t;

    // raw beat for the handshake side, operand view for the feeders
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            lanes_t b_col;  // byte j is B[j][i]
            lanes_t a_row;  // byte j is A[i][j]
        } operands;
    } in_word_u;

endpackage

// File: source/systolic_top.sv
/* 4x4 int8 matrix multiplier with valid/ready streams on both sides
   four input words per matrix pair, eight output words per result, done_o on the last one */
module systolic_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid_i,
    input  logic [systolic_pkg::WORD_W-1:0] in_data_i,
    output logic                            in_ready_o,
    output logic                            out_valid_o,
    output logic [systolic_pkg::WORD_W-1:0] out_data_o,
    input  logic                            out_ready_i,
    output logic                            done_o
);

    logic clear;
    logic snap;
    logic drained;
    logic [systolic_pkg::N*systolic_pkg::N-1:0][systolic_pkg::ACC_W-1:0] sums;

    feed_if feed_a ();  // rows of A
    feed_if feed_b ();  // columns of B

    mm_controller u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_valid_i (in_valid_i),
        .in_data_i  (in_data_i),
        .in_ready_o (in_ready_o),
        .feed_a     (feed_a),
        .feed_b     (feed_b),
        .clear_o    (clear),
        .snap_o     (snap),
        .drained_i  (drained)
    );

    operand_feeder u_feed_a (
        .clk   (clk),
        .reset (reset),
        .feed  (feed_a)
    );

    operand_feeder u_feed_b (
        .clk   (clk),
        .reset (reset),
        .feed  (feed_b)
    );

    pe_array u_array (
        .clk     (clk),
        .reset   (reset),
        .clear_i (clear),
        .feed_a  (feed_a),
        .feed_b  (feed_b),
        .sums_o  (sums)
    );

    result_unloader u_unload (
        .clk         (clk),
        .reset       (reset),
        .snap_i      (snap),
        .sums_i      (sums),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i),
        .drained_o   (drained)
    );

    assign done_o = drained;

endmodule

// File: tb/tb_systolic.sv
/* self-checking testbench for systolic_top; rows of A, B, input gaps and out_ready stalls
   come from a table, random rows use $urandom with a fixed seed and the run has a cycle limit */
module tb_systolic;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS  = 25;
    localparam int FIXED = 5;  // hand-written rows ahead of the random ones
    localparam int LIMIT = ROWS * (systolic_pkg::IN_BEATS + systolic_pkg::FEED_STEPS + 3
                           + systolic_pkg::OUT_BEATS * 4) + 200;

    logic                            clk;
    logic                            reset;
    logic                            in_valid_i;
    logic [systolic_pkg::WORD_W-1:0] in_data_i;
    logic                            in_ready_o;
    logic                            out_valid_o;
    logic [systolic_pkg::WORD_W-1:0] out_data_o;
    logic                            out_ready_i;
    logic                            done_o;

    byte         a_tab    [ROWS][systolic_pkg::N][systolic_pkg::N];
    byte         b_tab    [ROWS][systolic_pkg::N][systolic_pkg::N];
    logic [7:0]  gap_tab  [ROWS];  // two bits of idle cycles ahead of each input beat
    logic [31:0] rdy_tab  [ROWS];  // out_ready_i per drain cycle, repeats every 32
    string       name_tab [ROWS];

    logic [systolic_pkg::WORD_W-1:0] expect_words [systolic_pkg::OUT_BEATS];
    int err_count  = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    int cycles     = 0;

    systolic_top uut (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i),
        .done_o      (done_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run timed out after %0d cycles before all tests finished", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %s: passed", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic build_table();
        void'($urandom(32'hfb16_6703));  // one seed for the whole run
        for (int r = 0; r < ROWS; r++) begin
            gap_tab[r]  = '0;
            rdy_tab[r]  = '1;
            name_tab[r] = $sformatf("random %0d", r - FIXED);
            for (int i = 0; i < systolic_pkg::N; i++) begin
                for (int j = 0; j < systolic_pkg::N; j++) begin
                    a_tab[r][i][j] = byte'($urandom);
                    b_tab[r][i][j] = byte'($urandom);
                end
            end
            if (r >= FIXED) begin
                gap_tab[r] = 8'($urandom) & 8'h55;        // at most one idle cycle per beat
                rdy_tab[r] = $urandom | 32'h1111_1111;    // ready at least once in four cycles
            end
        end
        for (int i = 0; i < systolic_pkg::N; i++) begin
            for (int j = 0; j < systolic_pkg::N; j++) begin
                a_tab[0][i][j] = byte'((i == j) ? 1 : 0);
                b_tab[0][i][j] = byte'(9 * (4 * i + j) - 70);
                a_tab[1][i][j] = -128;
                b_tab[1][i][j] = -128;
                a_tab[2][i][j] = byte'(((i + j) % 2 == 1) ? 127 : -128);
                b_tab[2][i][j] = byte'((i == j || i + j == 3) ? -128 : 127);
            end
        end
        name_tab[0] = "identity times fixed B";
        name_tab[1] = "all -128";
        name_tab[2] = "mix of -128 and 127";
        name_tab[3] = "input gaps";
        gap_tab[3]  = 8'he7;          // gaps 3, 1, 2, 3
        name_tab[4] = "output back-pressure";
        rdy_tab[4]  = 32'h3511_9151;
    endtask

    // reference C = A * B, two sums per word, lower index in the low half
    task automatic compute_expected(input int r);
        int sum;
        int idx;
        for (int i = 0; i < systolic_pkg::N; i++) begin
            for (int j = 0; j < systolic_pkg::N; j++) begin
                sum = 0;
                for (int k = 0; k < systolic_pkg::N; k++) begin
                    sum += int'(a_tab[r][i][k]) * int'(b_tab[r][k][j]);
                end
                idx = i * systolic_pkg::N + j;
                if (idx % 2 == 0) begin
                    expect_words[idx / 2][31:0] = 32'(sum);
                end else begin
                    expect_words[idx / 2][63:32] = 32'(sum);
                end
            end
        end
    endtask

    // beat i: row i of A in the low bytes, column i of B in the high bytes
    function automatic logic [63:0] pack_beat(input int r, input int i);
        logic [63:0] w;
        for (int j = 0; j < systolic_pkg::N; j++) begin
            w[8*j +: 8]      = a_tab[r][i][j];
            w[32 + 8*j +: 8] = b_tab[r][j][i];
        end
        return w;
    endfunction

    task automatic check_reset_state();
        int errs_before;
        errs_before = err_count;
        @(posedge clk);
        check_equal("in_ready_o", 0, in_ready_o);
        check_equal("out_valid_o", 0, out_valid_o);
        check_equal("done_o", 0, done_o);
        @(posedge clk);
        check_equal("in_ready_o", 1, in_ready_o);  // one cycle after release
        report_test("reset state", errs_before);
    endtask

    task automatic run_row(input int r);
        int          errs_before;
        int          sent;
        int          gap;
        int          got;
        int          cyc;
        int          lat;
        logic        seen;
        logic        stalled;
        logic [63:0] held;
        errs_before = err_count;
        compute_expected(r);
        sent = 0;
        gap  = gap_tab[r][1:0];
        while (sent < systolic_pkg::IN_BEATS) begin
            @(posedge clk);
            if (in_valid_i && in_ready_o) begin
                sent++;
                if (sent < systolic_pkg::IN_BEATS) begin
                    gap = gap_tab[r][2*sent +: 2];
                end
            end
            if (sent < systolic_pkg::IN_BEATS && gap == 0) begin
                in_valid_i <= 1'b1;
                in_data_i  <= pack_beat(r, sent);
            end else begin
                in_valid_i <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
        got     = 0;
        cyc     = 0;
        lat     = 0;
        seen    = 1'b0;
        stalled = 1'b0;
        held    = '0;
        out_ready_i <= rdy_tab[r][0];
        while (got < systolic_pkg::OUT_BEATS) begin
            @(posedge clk);
            if (!seen) begin
                lat++;
                if (out_valid_o) begin
                    seen = 1'b1;
                    check_equal("out_valid_o latency", systolic_pkg::FEED_STEPS + 3, lat);
                end
            end
            if (stalled) begin  // word must hold while the sink stalls
                check_equal("out_valid_o", 1, out_valid_o);
                check_equal("out_data_o", held, out_data_o);
            end
            check_equal("done_o",
                        out_valid_o && out_ready_i && got == systolic_pkg::OUT_BEATS - 1, done_o);
            if (out_valid_o && out_ready_i) begin
                check_equal($sformatf("out_data_o word %0d", got), expect_words[got], out_data_o);
                got++;
            end
            stalled = out_valid_o && !out_ready_i;
            held    = out_data_o;
            cyc++;
            out_ready_i <= rdy_tab[r][cyc % 32];
        end
        @(posedge clk);
        check_equal("out_valid_o", 0, out_valid_o);
        check_equal("done_o", 0, done_o);
        report_test(name_tab[r], errs_before);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        out_ready_i = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        check_reset_state();
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);  // each row starts right after the previous drain
        end
        $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
